// ==== filelist.f ====
logic/arcade_pkg.sv
logic/ps2_receiver.sv
logic/key_mapper.sv
logic/input_combiner.sv
logic/video_blanker.sv
logic/sigma_delta_dac.sv
logic/board_shell.sv
tb/board_shell_assert.sv
tb/board_shell_tb.sv

// ==== logic/arcade_pkg.sv ====
package arcade_pkg;

	// keyboard side
	typedef logic [11:0] key_vec_t;

	localparam int KEY_RIGHT  = 0;
	localparam int KEY_LEFT   = 1;
	localparam int KEY_DOWN   = 2;
	localparam int KEY_UP     = 3;
	localparam int KEY_START1 = 5; // bit 4 unused
	localparam int KEY_START2 = 6;
	localparam int KEY_COIN1  = 7;
	localparam int KEY_W      = 8;
	localparam int KEY_S      = 9;
	localparam int KEY_A      = 10;
	localparam int KEY_D      = 11;

	// player controls into the game core, 11 bits
	typedef struct packed {
		logic r_right;
		logic r_left;
		logic r_down;
		logic r_up;
		logic l_right;
		logic l_left;
		logic l_down;
		logic l_up;
		logic start1;
		logic start2;
		logic coin1;
	} player_ctl_t;

	// core pixel, 3/3/2 colour plus timing
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
		logic       hblank;
		logic       vblank;
		logic       hs;
		logic       vs;
	} game_pixel_t;

	// board vga pins
	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} vga_out_t;

endpackage

// ==== logic/board_shell.sv ====
`timescale 1ns/1ps

module board_shell #(
	parameter int AUDIO_WIDTH = 16,
	parameter int FILTER_LEN  = 4
) (
	input  logic                    clock_48,
	input  logic                    reset,
	input  logic                    ce_pix,
	input  logic                    ps2_clk,
	input  logic                    ps2_data,
	input  logic [7:0]              joystick_0,
	input  logic [7:0]              joystick_1,
	input  logic [31:0]             status,
	input  logic [1:0]              buttons,
	input  logic [AUDIO_WIDTH-1:0]  audio,
	input  arcade_pkg::game_pixel_t pixel_in,
	output arcade_pkg::player_ctl_t controls,
	output logic                    game_reset,
	output logic [5:0]              vga_r,
	output logic [5:0]              vga_g,
	output logic [5:0]              vga_b,
	output logic                    vga_hs,
	output logic                    vga_vs,
	output logic                    audio_l,
	output logic                    audio_r,
	output logic                    led
);

	import arcade_pkg::*;

	logic [7:0] byte_data;
	logic       byte_valid;
	key_vec_t   keys;
	vga_out_t   vga;
	logic       audio_bit;

	ps2_receiver #(.FILTER_LEN(FILTER_LEN)) i_ps2_receiver (
		.clock_48   (clock_48),
		.reset      (reset),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.byte_data  (byte_data),
		.byte_valid (byte_valid)
	);

	key_mapper i_key_mapper (
		.clock_48   (clock_48),
		.reset      (reset),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.keys       (keys)
	);

	input_combiner i_input_combiner (
		.clock_48   (clock_48),
		.reset      (reset),
		.keys       (keys),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.buttons    (buttons),
		.controls   (controls),
		.game_reset (game_reset)
	);

	video_blanker i_video_blanker (
		.clock_48 (clock_48),
		.reset    (reset),
		.ce_pix   (ce_pix),
		.pixel_in (pixel_in),
		.vga      (vga)
	);

	sigma_delta_dac #(.AUDIO_WIDTH(AUDIO_WIDTH)) i_sigma_delta_dac (
		.clock_48  (clock_48),
		.reset     (reset),
		.audio     (audio),
		.audio_bit (audio_bit)
	);

	assign vga_r  = vga.r;
	assign vga_g  = vga.g;
	assign vga_b  = vga.b;
	assign vga_hs = vga.hs;
	assign vga_vs = vga.vs;

	assign audio_l = audio_bit; // mono core, same stream both sides
	assign audio_r = audio_bit;
	assign led     = 1'b1;

endmodule

// ==== logic/input_combiner.sv ====
`timescale 1ns/1ps

module input_combiner (
	input  logic                    clock_48,
	input  logic                    reset,
	input  arcade_pkg::key_vec_t    keys,
	input  logic [7:0]              joystick_0,
	input  logic [7:0]              joystick_1,
	input  logic [31:0]             status,
	input  logic [1:0]              buttons,
	output arcade_pkg::player_ctl_t controls,
	output logic                    game_reset
);

	import arcade_pkg::*;

	logic [7:0]  joy0_meta;
	logic [7:0]  joy0_sync;
	logic [7:0]  joy1_meta;
	logic [7:0]  joy1_sync;
	logic [2:0]  rst_meta; // status[0], status[6], buttons[1]
	logic [2:0]  rst_sync;
	player_ctl_t controls_next;

	// joystick bits: 0 up, 1 down, 2 right, 3 left
	always_comb begin
		controls_next.r_right = keys[KEY_RIGHT] | joy0_sync[2];
		controls_next.r_left  = keys[KEY_LEFT]  | joy0_sync[3];
		controls_next.r_down  = keys[KEY_DOWN]  | joy0_sync[1];
		controls_next.r_up    = keys[KEY_UP]    | joy0_sync[0];
		controls_next.l_right = keys[KEY_D]     | joy0_sync[2]; // joystick_0, as on the board
		controls_next.l_left  = keys[KEY_A]     | joy1_sync[3];
		controls_next.l_down  = keys[KEY_S]     | joy1_sync[1];
		controls_next.l_up    = keys[KEY_W]     | joy1_sync[0];
		controls_next.start1  = keys[KEY_START1];
		controls_next.start2  = keys[KEY_START2];
		controls_next.coin1   = keys[KEY_COIN1];
	end

	always_ff @(posedge clock_48) begin
		if (reset) begin
			joy0_meta  <= '0;
			joy0_sync  <= '0;
			joy1_meta  <= '0;
			joy1_sync  <= '0;
			rst_meta   <= '0;
			rst_sync   <= '0;
			controls   <= '0;
			game_reset <= 1'b0;
		end else begin
			joy0_meta  <= joystick_0;
			joy0_sync  <= joy0_meta;
			joy1_meta  <= joystick_1;
			joy1_sync  <= joy1_meta;
			rst_meta   <= {buttons[1], status[6], status[0]};
			rst_sync   <= rst_meta;
			controls   <= controls_next;
			game_reset <= |rst_sync;
		end
	end

endmodule

// ==== logic/key_mapper.sv ====
`timescale 1ns/1ps

module key_mapper (
	input  logic                 clock_48,
	input  logic                 reset,
	input  logic [7:0]           byte_data,
	input  logic                 byte_valid,
	output arcade_pkg::key_vec_t keys
);

	import arcade_pkg::*;

	localparam logic [7:0] CODE_EXTEND  = 8'hE0;
	localparam logic [7:0] CODE_RELEASE = 8'hF0;

	logic       extended;
	logic       released;
	logic       hit;
	logic [3:0] key_index;

	// set 2 scan codes; arrows only after E0
	always_comb begin
		hit = 1'b1;
		key_index = 4'd0;
		if (extended) begin
			case (byte_data)
				8'h74:   key_index = 4'(KEY_RIGHT);
				8'h6B:   key_index = 4'(KEY_LEFT);
				8'h72:   key_index = 4'(KEY_DOWN);
				8'h75:   key_index = 4'(KEY_UP);
				default: hit = 1'b0;
			endcase
		end else begin
			case (byte_data)
				8'h1D:   key_index = 4'(KEY_W);
				8'h1B:   key_index = 4'(KEY_S);
				8'h1C:   key_index = 4'(KEY_A);
				8'h23:   key_index = 4'(KEY_D);
				8'h16:   key_index = 4'(KEY_START1); // '1'
				8'h1E:   key_index = 4'(KEY_START2); // '2'
				8'h2E:   key_index = 4'(KEY_COIN1);  // '5'
				default: hit = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clock_48) begin
		if (reset) begin
			extended <= 1'b0;
			released <= 1'b0;
			keys     <= '0;
		end else if (byte_valid) begin
			if (byte_data == CODE_EXTEND) begin
				extended <= 1'b1;
			end else if (byte_data == CODE_RELEASE) begin
				released <= 1'b1;
			end else begin
				extended <= 1'b0; // prefixes only last one code
				released <= 1'b0;
				if (hit)
					keys[key_index] <= ~released;
			end
		end
	end

endmodule

// ==== logic/ps2_receiver.sv ====
`timescale 1ns/1ps

module ps2_receiver #(
	parameter int FILTER_LEN = 4
) (
	input  logic       clock_48,
	input  logic       reset,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic [7:0] byte_data,
	output logic       byte_valid
);

	localparam int IDLE_LIMIT = 2000;

	logic [1:0]            clk_sync;
	logic [1:0]            data_sync;
	logic [FILTER_LEN-1:0] clk_hist;
	logic                  clk_filt;
	logic                  fall;
	logic [3:0]            bit_count;
	logic [9:0]            shift_reg;
	logic [10:0]           idle_count;
	logic                  frame_ok;
	logic                  last_bit;

	// pins are asynchronous, idle high
	always_ff @(posedge clock_48) begin
		if (reset) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_hist  <= '1;
			clk_filt  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_hist  <= {clk_hist[FILTER_LEN-2:0], clk_sync[1]};
			if (&clk_hist)
				clk_filt <= 1'b1;
			else if (~|clk_hist)
				clk_filt <= 1'b0;
		end
	end

	assign fall     = clk_filt & ~|clk_hist; // filtered level about to drop
	assign last_bit = (bit_count == 4'd10);

	// start low, odd parity over data+parity, stop high
	assign frame_ok = ~shift_reg[0] & data_sync[1] & (^shift_reg[9:1]);

	always_ff @(posedge clock_48) begin
		if (reset) begin
			bit_count  <= '0;
			idle_count <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			if (fall) begin
				idle_count <= '0;
				if (last_bit) begin
					bit_count  <= '0;
					byte_valid <= frame_ok;
				end else begin
					bit_count <= bit_count + 4'd1;
				end
			end else if (bit_count != 4'd0) begin
				if (idle_count == 11'(IDLE_LIMIT - 1)) begin
					bit_count  <= '0; // drop partial frame
					idle_count <= '0;
				end else begin
					idle_count <= idle_count + 11'd1;
				end
			end else begin
				idle_count <= '0;
			end
		end
	end

	always_ff @(posedge clock_48) begin
		if (fall && !last_bit)
			shift_reg <= {data_sync[1], shift_reg[9:1]}; // lsb first
		if (fall && last_bit && frame_ok)
			byte_data <= shift_reg[8:1];
	end

endmodule

// ==== logic/sigma_delta_dac.sv ====
`timescale 1ns/1ps

module sigma_delta_dac #(
	parameter int AUDIO_WIDTH = 16
) (
	input  logic                   clock_48,
	input  logic                   reset,
	input  logic [AUDIO_WIDTH-1:0] audio,
	output logic                   audio_bit
);

	logic [AUDIO_WIDTH:0] acc; // one guard bit for the carry

	// carry leaves the loop each cycle, remainder is kept
	always_ff @(posedge clock_48) begin
		if (reset)
			acc <= '0;
		else
			acc <= {1'b0, acc[AUDIO_WIDTH-1:0]} + {1'b0, audio};
	end

	assign audio_bit = acc[AUDIO_WIDTH];

endmodule

// ==== logic/video_blanker.sv ====
`timescale 1ns/1ps

module video_blanker (
	input  logic                    clock_48,
	input  logic                    reset,
	input  logic                    ce_pix,
	input  arcade_pkg::game_pixel_t pixel_in,
	output arcade_pkg::vga_out_t    vga
);

	import arcade_pkg::*;

	logic       blank;
	logic [2:0] r3;
	logic [2:0] g3;
	logic [2:0] b3;
	vga_out_t   vga_next;

	always_comb begin
		blank = pixel_in.hblank | pixel_in.vblank;
		r3 = blank ? 3'b000 : pixel_in.r;
		g3 = blank ? 3'b000 : pixel_in.g;
		b3 = blank ? 3'b000 : {pixel_in.b, pixel_in.b[0]}; // blue to 3 bits first

		// repeat 3 bits twice for 6-bit dac
		vga_next.r  = {r3, r3};
		vga_next.g  = {g3, g3};
		vga_next.b  = {b3, b3};
		vga_next.hs = pixel_in.hs;
		vga_next.vs = pixel_in.vs;
	end

	always_ff @(posedge clock_48) begin
		if (reset)
			vga <= '0;
		else if (ce_pix)
			vga <= vga_next; // one pixel of latency
	end

endmodule

// ==== tb/board_shell_assert.sv ====
`timescale 1ns/1ps

module board_shell_assert (
	input logic                    clock_48,
	input logic                    reset,
	input logic                    ce_pix,
	input logic                    byte_valid,
	input arcade_pkg::game_pixel_t pixel_in,
	input logic [31:0]             status,
	input logic [1:0]              buttons,
	input arcade_pkg::player_ctl_t controls,
	input logic                    game_reset,
	input logic [5:0]              vga_r,
	input logic [5:0]              vga_g,
	input logic [5:0]              vga_b,
	input logic                    vga_hs,
	input logic                    vga_vs,
	input logic                    audio_l,
	input logic                    audio_r,
	input logic                    led
);

	int unsigned fail_count = 0;
	logic        reset_src;

	assign reset_src = status[0] | status[6] | buttons[1];

	byte_valid_single: assert property (@(posedge clock_48) disable iff (reset)
		byte_valid |=> !byte_valid)
	else begin
		$error("byte_valid stayed high for more than one cycle");
		fail_count = fail_count + 1;
	end

	// colour register loads on the enabled edge
	blank_zero: assert property (@(posedge clock_48) disable iff (reset)
		(ce_pix && (pixel_in.hblank || pixel_in.vblank))
			|=> (vga_r == 6'd0 && vga_g == 6'd0 && vga_b == 6'd0))
	else begin
		$error("blanked pixel gave nonzero vga colour");
		fail_count = fail_count + 1;
	end

	reset_latency: assert property (@(posedge clock_48) disable iff (reset)
		game_reset == $past(reset_src, 3)) // two sync flops plus output flop
	else begin
		$error("game_reset did not follow its sources 3 cycles later");
		fail_count = fail_count + 1;
	end

	outputs_known: assert property (@(posedge clock_48) disable iff (reset)
		!$isunknown({controls, game_reset, vga_r, vga_g, vga_b, vga_hs, vga_vs,
			audio_l, audio_r, led}))
	else begin
		$error("an output is unknown after reset");
		fail_count = fail_count + 1;
	end

endmodule

// ==== tb/board_shell_tb.sv ====
`timescale 1ns/1ps

module board_shell_tb;

	import arcade_pkg::*;

	localparam int AUDIO_WIDTH    = 16;
	localparam int BIT_CYCLES     = 40;    // slow ps2 bit period
	localparam int TIMEOUT_CYCLES = 60000; // 9 frames of 440, 1k audio, video, wide margin

	logic                   clock_48;
	logic                   reset;
	logic                   ce_pix;
	logic                   ps2_clk;
	logic                   ps2_data;
	logic [7:0]             joystick_0;
	logic [7:0]             joystick_1;
	logic [31:0]            status;
	logic [1:0]             buttons;
	logic [AUDIO_WIDTH-1:0] audio;
	game_pixel_t            pixel_in;
	player_ctl_t            controls;
	logic                   game_reset;
	logic [5:0]             vga_r;
	logic [5:0]             vga_g;
	logic [5:0]             vga_b;
	logic                   vga_hs;
	logic                   vga_vs;
	logic                   audio_l;
	logic                   audio_r;
	logic                   led;

	int errors;
	int cycles;
	int valid_count;

	board_shell #(.AUDIO_WIDTH(AUDIO_WIDTH), .FILTER_LEN(4)) i_board_shell (.*);

	bind board_shell board_shell_assert i_board_shell_assert (.*);

	always #10 clock_48 = ~clock_48;

	always @(posedge clock_48) begin
		if (i_board_shell.byte_valid)
			valid_count++;
		cycles++;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			close_run(1'b1);
		end
	end

	task automatic close_run(input bit timed_out);
		int fails;
		fails = i_board_shell.i_board_shell_assert.fail_count;
		$display("Check errors: %0d, assertion failures: %0d", errors, fails);
		if (errors == 0 && fails == 0 && !timed_out)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	// start, 8 data lsb first, parity, stop
	task automatic send_frame(input logic [7:0] data, input bit good_parity);
		logic [10:0] bits;
		bits = {1'b1, (good_parity ? ~^data : ^data), data, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_data = bits[i];
			repeat (BIT_CYCLES / 2) @(negedge clock_48);
			ps2_clk = 1'b0;
			repeat (BIT_CYCLES / 2) @(negedge clock_48);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
	endtask

	task automatic send_byte(input logic [7:0] data);
		int start;
		int waited;
		start = valid_count;
		waited = 0;
		send_frame(data, 1'b1);
		while (valid_count == start && waited < 2 * BIT_CYCLES) begin
			@(negedge clock_48);
			waited++;
		end
		assert (valid_count == start + 1) else begin
			$display("Error: frame %h did not give exactly one byte_valid pulse", data);
			errors++;
		end
		repeat (2) @(negedge clock_48); // keys, then controls
	endtask

	task automatic expect_controls(input player_ctl_t exp);
		assert (controls == exp) else begin
			$display("Error controls: got %h expected %h", controls, exp);
			errors++;
		end
	endtask

	task automatic expect_keys(input key_vec_t exp_keys, input player_ctl_t exp_ctl);
		assert (i_board_shell.keys == exp_keys) else begin
			$display("Error keys: got %h expected %h", i_board_shell.keys, exp_keys);
			errors++;
		end
		expect_controls(exp_ctl);
	endtask

	task automatic expect_reset(input logic exp);
		assert (game_reset == exp) else begin
			$display("Error game_reset: got %h expected %h", game_reset, exp);
			errors++;
		end
	endtask

	task automatic expect_vga(input vga_out_t exp);
		assert ({vga_r, vga_g, vga_b, vga_hs, vga_vs} == exp) else begin
			$display("Error vga: got %h expected %h",
				{vga_r, vga_g, vga_b, vga_hs, vga_vs}, exp);
			errors++;
		end
	endtask

	// blank forces colour to 0, 3-bit fields doubled, blue b,b[0] first
	function automatic vga_out_t widen_pixel(input game_pixel_t p);
		vga_out_t v;
		logic     blank;
		blank = p.hblank | p.vblank;
		v.r = blank ? 6'd0 : {2{p.r}};
		v.g = blank ? 6'd0 : {2{p.g}};
		v.b = blank ? 6'd0 : {2{p.b, p.b[0]}};
		v.hs = p.hs;
		v.vs = p.vs;
		return v;
	endfunction

	task automatic check_reset_source(input logic [31:0] st, input logic [1:0] bt);
		status = st;
		buttons = bt;
		repeat (2) @(negedge clock_48);
		expect_reset(1'b0);
		@(negedge clock_48);
		expect_reset(1'b1);
		status = '0;
		buttons = '0;
		repeat (3) @(negedge clock_48);
		expect_reset(1'b0);
	endtask

	task automatic run_audio();
		int     ones;
		longint diff;
		ones = 0;
		for (int i = 0; i < 1024; i++) begin
			@(negedge clock_48);
			ones += audio_l;
			assert (audio_r == audio_l) else begin
				$display("Error audio_r: got %h expected %h", audio_r, audio_l);
				errors++;
			end
		end
		diff = longint'(ones) * (longint'(1) << AUDIO_WIDTH) - 1024 * longint'(audio);
		assert (diff <= (longint'(1) << AUDIO_WIDTH) && diff >= -(longint'(1) << AUDIO_WIDTH))
		else begin
			$display("Error audio_l ones: got %h expected %h", ones,
				(1024 * longint'(audio)) >> AUDIO_WIDTH);
			errors++;
		end
	endtask

	task automatic run_video();
		game_pixel_t pix;
		vga_out_t    exp;
		for (int i = 0; i < 48; i++) begin
			pix = game_pixel_t'(12'($urandom()));
			pix.hblank = (i % 4 == 0);
			pix.vblank = (i % 7 == 0);
			pixel_in = pix;
			ce_pix = 1'b1;
			@(negedge clock_48);
			ce_pix = 1'b0;
			pixel_in = game_pixel_t'(12'($urandom())); // must not reach vga
			exp = widen_pixel(pix);
			expect_vga(exp);
			@(negedge clock_48);
			expect_vga(exp);
		end
	endtask

	initial begin
		player_ctl_t exp_ctl;
		int          start;
		void'($urandom(32'heb9e));
		errors = 0;
		cycles = 0;
		valid_count = 0;
		clock_48 = 1'b0;
		reset = 1'b1;
		ce_pix = 1'b0;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		joystick_0 = '0;
		joystick_1 = '0;
		status = '0;
		buttons = '0;
		pixel_in = '0;
		audio = AUDIO_WIDTH'($urandom()); // held from reset
		repeat (8) @(negedge clock_48);
		reset = 1'b0;
		@(negedge clock_48);
		expect_keys('0, '0);
		expect_reset(1'b0);
		expect_vga('0);
		assert (led == 1'b1) else begin
			$display("Error led: got %h expected %h", led, 1'b1);
			errors++;
		end

		run_audio();

		send_byte(8'hE0);
		send_byte(8'h74);
		exp_ctl = '0;
		exp_ctl.r_right = 1'b1;
		expect_keys(12'h001, exp_ctl); // right arrow
		send_byte(8'hE0);
		send_byte(8'hF0);
		send_byte(8'h74);
		expect_keys('0, '0);
		send_byte(8'h1C);
		exp_ctl = '0;
		exp_ctl.l_left = 1'b1;
		expect_keys(12'h400, exp_ctl); // A key

		start = valid_count;
		send_frame(8'h2E, 1'b0); // coin code, wrong parity
		repeat (BIT_CYCLES) @(negedge clock_48);
		assert (valid_count == start) else begin
			$display("Error: frame with wrong parity gave a byte_valid pulse");
			errors++;
		end
		expect_keys(12'h400, exp_ctl);
		send_byte(8'hF0);
		send_byte(8'h1C);
		expect_keys('0, '0);

		joystick_0 = 8'h01; // up
		repeat (2) @(negedge clock_48);
		expect_controls('0);
		@(negedge clock_48);
		exp_ctl = '0;
		exp_ctl.r_up = 1'b1;
		expect_controls(exp_ctl);
		joystick_0 = '0;
		joystick_1 = 8'h08; // left
		repeat (2) @(negedge clock_48);
		expect_controls(exp_ctl);
		@(negedge clock_48);
		exp_ctl = '0;
		exp_ctl.l_left = 1'b1;
		expect_controls(exp_ctl);
		joystick_1 = '0;
		repeat (3) @(negedge clock_48);
		expect_controls('0);

		check_reset_source(32'h0000_0001, 2'b00);
		check_reset_source(32'h0000_0040, 2'b00);
		check_reset_source(32'h0000_0000, 2'b10);

		run_video();
		close_run(1'b0);
	end

endmodule
